// ==== hdl/mem_tile_macro.sv ====
// Behavioral SRAM macro
// Registered read, bit-masked write and a power-down mode that either
// keeps or clears the contents depending on the retention request

`timescale 1ns/1ps

module mem_tile_macro import mem_tile_pkg::*; (
    input  logic          Clk,
    input  logic          RstN,
    input  logic          i_rd_en,
    input  macro_addr_t   i_rd_addr,
    output macro_data_t   o_rd_data,
    input  logic          i_wr_en,
    input  macro_addr_t   i_wr_addr,
    input  macro_data_t   i_wr_bit_en,
    input  macro_data_t   i_wr_data,
    input  mem_impl_in_t  i_impl,
    output mem_impl_out_t o_impl
);

    macro_data_t mem_q [MACRO_DEPTH];
    logic        prn_q;
    logic        pde_rise;
    logic        clear_en;

    // prn_q still holds the previous pde, so a mismatch marks the rising edge
    assign pde_rise = i_impl.pde & ~prn_q;
    assign clear_en = pde_rise & ~i_impl.ret;

    // Storage array
    always_ff @(posedge Clk) begin
        if (clear_en) begin
            for (int unsigned w = 0; w < MACRO_DEPTH; w++) begin
                mem_q[w] <= '0;
            end
        end else if (i_wr_en && !i_impl.pde) begin
            mem_q[i_wr_addr] <= (mem_q[i_wr_addr] & ~i_wr_bit_en)
                              | (i_wr_data & i_wr_bit_en);
        end
    end

    // Read register holds its word until the next read
    always_ff @(posedge Clk or negedge RstN) begin
        if (!RstN) begin
            o_rd_data <= '0;
        end else if (i_impl.pde) begin
            o_rd_data <= '0;
        end else if (i_rd_en) begin
            o_rd_data <= mem_q[i_rd_addr];
        end
    end

    // One stage of the power chain
    always_ff @(posedge Clk or negedge RstN) begin
        if (!RstN) begin
            prn_q <= 1'b0;
        end else begin
            prn_q <= i_impl.pde;
        end
    end

    assign o_impl.prn = prn_q;

endmodule

// ==== hdl/mem_tile_pkg.sv ====
// Memory tile shared definitions
// Geometry of the logical memory and of the SRAM macros it is built from,
// the vector types that carry addresses and data, and the low-power chain structs

package mem_tile_pkg;

    // Logical memory seen at the top level ports
    localparam int unsigned DATAW = 40;
    localparam int unsigned DEPTH = 100;

    // Fixed macro geometry, depth kept a power of two so ranks decode cleanly
    localparam int unsigned MACRO_DATAW = 16;
    localparam int unsigned MACRO_DEPTH = 32;

    // Number of depth ranks, rounded up so a partial last rank is allowed
    localparam int unsigned MACRO_COUNT = (DEPTH + MACRO_DEPTH - 1) / MACRO_DEPTH;

    // Macros side by side in one rank, the last one only partly used
    localparam int unsigned SLICE_COUNT = (DATAW + MACRO_DATAW - 1) / MACRO_DATAW;

    // Width of one rank once padded to whole macros
    localparam int unsigned EXT_DATAW = SLICE_COUNT * MACRO_DATAW;

    // Address widths
    localparam int unsigned ADDRW       = $clog2(DEPTH);
    localparam int unsigned MACRO_ADDRW = $clog2(MACRO_DEPTH);
    localparam int unsigned RANK_ADDRW  = $clog2(MACRO_COUNT);

    // Every macro sits on the power chain once
    localparam int unsigned CHAIN_LEN = MACRO_COUNT * SLICE_COUNT;

    // Logical address and data word, the bit enable shares the data type
    typedef logic [ADDRW-1:0] mem_addr_t;
    typedef logic [DATAW-1:0] mem_data_t;

    // Address and data of a single macro
    typedef logic [MACRO_ADDRW-1:0] macro_addr_t;
    typedef logic [MACRO_DATAW-1:0] macro_data_t;

    // One-hot rank select
    typedef logic [MACRO_COUNT-1:0] rank_sel_t;

    // Low-power request travelling down the chain
    typedef struct packed {
        logic pde;  // power-down request
        logic ret;  // keep contents while powered down
    } mem_impl_in_t;

    // Status returned along the chain
    typedef struct packed {
        logic prn;  // power-down has reached this point
    } mem_impl_out_t;

endpackage

// ==== hdl/mem_tile_pwr_chain.sv ====
// Memory tile power-down chain
// Hands the low-power request from rank to rank, each rank starting its
// power-down once the previous one reports it is done

`timescale 1ns/1ps

module mem_tile_pwr_chain import mem_tile_pkg::*; (
    input  mem_impl_in_t                    i_impl,
    output mem_impl_out_t                   o_impl,
    output mem_impl_in_t  [MACRO_COUNT-1:0] o_rank_impl,
    input  mem_impl_out_t [MACRO_COUNT-1:0] i_rank_impl
);

    // Rank 0 sees the request straight from the ports
    assign o_rank_impl[0] = i_impl;

    for (genvar r = 1; r < MACRO_COUNT; r++) begin : g_rank
        // Serial hand-off keeps the power-up and power-down in order
        assign o_rank_impl[r].pde = i_rank_impl[r-1].prn;

        // Retention is a level shared by the whole memory
        assign o_rank_impl[r].ret = i_impl.ret;
    end

    // Last rank closes the chain
    assign o_impl = i_rank_impl[MACRO_COUNT-1];

endmodule

// ==== hdl/mem_tile_top.sv ====
// Memory tile top level
// One logical memory built from ranks of SRAM macros, with rank decode,
// a registered read select for the one-hot read mux and the power chain

`timescale 1ns/1ps

module mem_tile_top import mem_tile_pkg::*; (
    input  logic          Clk,
    input  logic          RstN,
    input  logic          i_rd_en,
    input  mem_addr_t     i_rd_addr,
    output mem_data_t     o_rd_data,
    input  logic          i_wr_en,
    input  mem_addr_t     i_wr_addr,
    input  mem_data_t     i_wr_bit_en,
    input  mem_data_t     i_wr_data,
    input  mem_impl_in_t  i_impl,
    output mem_impl_out_t o_impl
);

    logic [RANK_ADDRW-1:0] rd_rank;
    logic [RANK_ADDRW-1:0] wr_rank;
    rank_sel_t             rd_sel;
    rank_sel_t             wr_sel;
    rank_sel_t             rd_sel_q;
    rank_sel_t             rank_rd_en;
    rank_sel_t             rank_wr_en;
    macro_addr_t           rd_macro_addr;
    macro_addr_t           wr_macro_addr;

    mem_data_t     [MACRO_COUNT-1:0] rank_rd_data;
    mem_impl_in_t  [MACRO_COUNT-1:0] rank_impl_in;
    mem_impl_out_t [MACRO_COUNT-1:0] rank_impl_out;

    // Upper address bits pick the rank, lower bits address inside it
    assign rd_rank       = i_rd_addr[MACRO_ADDRW +: RANK_ADDRW];
    assign wr_rank       = i_wr_addr[MACRO_ADDRW +: RANK_ADDRW];
    assign rd_macro_addr = i_rd_addr[MACRO_ADDRW-1:0];
    assign wr_macro_addr = i_wr_addr[MACRO_ADDRW-1:0];

    assign rd_sel = rank_sel_t'(1) << rd_rank;
    assign wr_sel = rank_sel_t'(1) << wr_rank;

    assign rank_rd_en = {MACRO_COUNT{i_rd_en}} & rd_sel;
    assign rank_wr_en = {MACRO_COUNT{i_wr_en}} & wr_sel;

    // Select follows the macro read latency and holds with the read data
    always_ff @(posedge Clk or negedge RstN) begin
        if (!RstN) begin
            rd_sel_q <= '0;
        end else if (i_rd_en) begin
            rd_sel_q <= rd_sel;
        end
    end

    // One-hot read mux, all zero until the first read
    always_comb begin
        o_rd_data = '0;
        for (int unsigned r = 0; r < MACRO_COUNT; r++) begin
            o_rd_data = o_rd_data | (rank_rd_data[r] & {DATAW{rd_sel_q[r]}});
        end
    end

    mem_tile_pwr_chain u_pwr_chain (
        .i_impl      (i_impl),
        .o_impl      (o_impl),
        .o_rank_impl (rank_impl_in),
        .i_rank_impl (rank_impl_out)
    );

    for (genvar r = 0; r < MACRO_COUNT; r++) begin : g_rank
        mem_tile_width_ext u_rank (
            .Clk         (Clk),
            .RstN        (RstN),
            .i_rd_en     (rank_rd_en[r]),
            .i_rd_addr   (rd_macro_addr),
            .o_rd_data   (rank_rd_data[r]),
            .i_wr_en     (rank_wr_en[r]),
            .i_wr_addr   (wr_macro_addr),
            .i_wr_bit_en (i_wr_bit_en),
            .i_wr_data   (i_wr_data),
            .i_impl      (rank_impl_in[r]),
            .o_impl      (rank_impl_out[r])
        );
    end

    // The last rank may be partial, so addresses past DEPTH hit unused words
    ast_rd_addr_in_range : assert property (
        @(posedge Clk) disable iff (!RstN) i_rd_en |-> (i_rd_addr < DEPTH)
    ) else $error("Read address 0x%0x out of range [0, 0x%0x]", i_rd_addr, DEPTH-1);

    ast_wr_addr_in_range : assert property (
        @(posedge Clk) disable iff (!RstN) i_wr_en |-> (i_wr_addr < DEPTH)
    ) else $error("Write address 0x%0x out of range [0, 0x%0x]", i_wr_addr, DEPTH-1);

endmodule

// ==== hdl/mem_tile_width_ext.sv ====
// Memory tile depth rank
// Places macros side by side to cover the full data width and threads
// the power-down chain through them from the lowest slice upwards

`timescale 1ns/1ps

module mem_tile_width_ext import mem_tile_pkg::*; (
    input  logic          Clk,
    input  logic          RstN,
    input  logic          i_rd_en,
    input  macro_addr_t   i_rd_addr,
    output mem_data_t     o_rd_data,
    input  logic          i_wr_en,
    input  macro_addr_t   i_wr_addr,
    input  mem_data_t     i_wr_bit_en,
    input  mem_data_t     i_wr_data,
    input  mem_impl_in_t  i_impl,
    output mem_impl_out_t o_impl
);

    logic [EXT_DATAW-1:0] wr_data_ext;
    logic [EXT_DATAW-1:0] wr_bit_en_ext;
    logic [EXT_DATAW-1:0] rd_data_ext;

    mem_impl_in_t  [SLICE_COUNT-1:0] slice_impl_in;
    mem_impl_out_t [SLICE_COUNT-1:0] slice_impl_out;

    // Unused top bits of the last slice are never written
    assign wr_data_ext   = {{(EXT_DATAW-DATAW){1'b0}}, i_wr_data};
    assign wr_bit_en_ext = {{(EXT_DATAW-DATAW){1'b0}}, i_wr_bit_en};
    assign o_rd_data     = rd_data_ext[DATAW-1:0];

    for (genvar s = 0; s < SLICE_COUNT; s++) begin : g_slice
        // Slice 0 takes the rank request, later slices wait on the one before
        if (s == 0) begin : g_first
            assign slice_impl_in[s] = i_impl;
        end else begin : g_next
            assign slice_impl_in[s].pde = slice_impl_out[s-1].prn;
            assign slice_impl_in[s].ret = i_impl.ret;
        end

        mem_tile_macro u_macro (
            .Clk         (Clk),
            .RstN        (RstN),
            .i_rd_en     (i_rd_en),
            .i_rd_addr   (i_rd_addr),
            .o_rd_data   (rd_data_ext[s*MACRO_DATAW +: MACRO_DATAW]),
            .i_wr_en     (i_wr_en),
            .i_wr_addr   (i_wr_addr),
            .i_wr_bit_en (wr_bit_en_ext[s*MACRO_DATAW +: MACRO_DATAW]),
            .i_wr_data   (wr_data_ext[s*MACRO_DATAW +: MACRO_DATAW]),
            .i_impl      (slice_impl_in[s]),
            .o_impl      (slice_impl_out[s])
        );
    end

    assign o_impl = slice_impl_out[SLICE_COUNT-1];

endmodule

// ==== mem_tile.f ====
hdl/mem_tile_pkg.sv
hdl/mem_tile_macro.sv
hdl/mem_tile_width_ext.sv
hdl/mem_tile_pwr_chain.sv
hdl/mem_tile_top.sv
verif/mem_tile_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the mem_tile testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mem_tile_tb \
    -f mem_tile.f -Mdir obj_dir -o mem_tile_sim > build.log 2>&1 &&
    ./obj_dir/mem_tile_sim | tee sim.log ||
    echo "Build or simulation step returned an error, see build.log"

grep -q "^Testbench passed$" sim.log && echo "Result: PASS" ||
    { echo "Result: FAIL"; exit 1; }

// ==== verif/mem_tile_tb.sv ====
// Memory tile testbench
// Drives reads, bit-masked writes and power-down sequences into the tile
// and checks them against a reference memory model

`timescale 1ns/1ps

module mem_tile_tb import mem_tile_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int N_RAND       = 400;
    // Rough cycle budget of all tests together
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 * DEPTH + N_RAND + 2 * CHAIN_LEN
                                + 2 * (8 * CHAIN_LEN + DEPTH) + 50;
    localparam int WD_MARGIN    = 200;

    logic          Clk;
    logic          RstN;
    logic          rd_en;
    mem_addr_t     rd_addr;
    mem_data_t     rd_data;
    logic          wr_en;
    mem_addr_t     wr_addr;
    mem_data_t     wr_bit_en;
    mem_data_t     wr_data;
    mem_impl_in_t  impl_in;
    mem_impl_out_t impl_out;

    mem_data_t ref_mem [DEPTH];
    mem_data_t exp_rd;
    mem_addr_t exp_addr;
    logic      rd_check;
    logic      pde_prev;
    integer    seed = 32'he4e52eb3;
    string     test_name;
    int        test_count;
    int        check_count;
    int        err_count;
    int        test_checks;
    int        test_errs;

    mem_tile_top mem_tile_top_inst (
        .Clk         (Clk),
        .RstN        (RstN),
        .i_rd_en     (rd_en),
        .i_rd_addr   (rd_addr),
        .o_rd_data   (rd_data),
        .i_wr_en     (wr_en),
        .i_wr_addr   (wr_addr),
        .i_wr_bit_en (wr_bit_en),
        .i_wr_data   (wr_data),
        .i_impl      (impl_in),
        .o_impl      (impl_out)
    );

    initial begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    // Expected word after a masked write, or zero after a power clear
    function automatic mem_data_t ref_word(mem_data_t old_word, mem_data_t data,
                                           mem_data_t bit_en, logic clear);
        mem_data_t word;
        word = '0;
        if (!clear) begin
            for (int b = 0; b < DATAW; b++) begin
                word[b] = bit_en[b] ? data[b] : old_word[b];
            end
        end
        return word;
    endfunction

    function automatic mem_addr_t rand_addr();
        return mem_addr_t'($unsigned($random(seed)) % DEPTH);
    endfunction

    function automatic mem_data_t rand_word();
        return mem_data_t'({$random(seed), $random(seed)});
    endfunction

    task automatic check_data(string name, mem_data_t exp, mem_data_t act);
        check_count++;
        test_checks++;
        if (act !== exp) begin
            $display("mismatch %s %s: expected %h, actual %h", test_name, name, exp, act);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic check_impl(string name, mem_impl_out_t exp, mem_impl_out_t act);
        check_count++;
        test_checks++;
        if (act !== exp) begin
            $display("mismatch %s %s: expected %b, actual %b", test_name, name, exp, act);
            err_count++;
            test_errs++;
        end
    endtask

    // Predict each read from the model at the strobe, then apply the write
    always @(posedge Clk) begin
        rd_check = RstN && rd_en;
        if (rd_check) begin
            exp_rd   = ref_mem[rd_addr];
            exp_addr = rd_addr;
        end
        if (RstN && impl_in.pde && !pde_prev && !impl_in.ret) begin
            for (int w = 0; w < DEPTH; w++) begin
                ref_mem[w] = ref_word(ref_mem[w], '0, '0, 1'b1);
            end
        end
        pde_prev = impl_in.pde;
        if (RstN && wr_en) begin
            ref_mem[wr_addr] = ref_word(ref_mem[wr_addr], wr_data, wr_bit_en, 1'b0);
        end
    end

    // Read data is stable by the falling edge after the strobe
    always @(negedge Clk) begin
        if (rd_check) begin
            check_data($sformatf("read 0x%0h", exp_addr), exp_rd, rd_data);
        end
    end

    task automatic drive_cycle(logic rd, mem_addr_t ra, logic wr, mem_addr_t wa,
                               mem_data_t be, mem_data_t wd);
        @(posedge Clk);
        #1;
        rd_en     = rd;
        rd_addr   = ra;
        wr_en     = wr;
        wr_addr   = wa;
        wr_bit_en = be;
        wr_data   = wd;
    endtask

    task automatic start_test(string name);
        test_name   = name;
        test_checks = 0;
        test_errs   = 0;
    endtask

    task automatic finish_test();
        drive_cycle(1'b0, '0, 1'b0, '0, '0, '0);
        repeat (2) @(negedge Clk);
        #1;
        $display("%-16s %0d checks, %0d errors", test_name, test_checks, test_errs);
        test_count++;
    endtask

    task automatic read_all();
        for (int a = 0; a < DEPTH; a++) begin
            drive_cycle(1'b1, mem_addr_t'(a), 1'b0, '0, '0, '0);
        end
    endtask

    task automatic wait_prn(logic level);
        int n;
        n = 0;
        while (impl_out.prn !== level && n < 4 * CHAIN_LEN) begin
            @(negedge Clk);
            n++;
        end
        if (impl_out.prn !== level) begin
            $display("%s: prn did not reach %b within %0d cycles", test_name, level, n);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic power_cycle(logic ret);
        @(posedge Clk);
        #1;
        impl_in.ret = ret;
        impl_in.pde = 1'b1;
        wait_prn(1'b1);
        repeat (4) @(posedge Clk);
        #1;
        impl_in.pde = 1'b0;
        wait_prn(1'b0);
        @(posedge Clk);
        #1;
        impl_in.ret = 1'b0;
    endtask

    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + WD_MARGIN));
        $display("Timeout: the tests did not finish in %0d cycles", TEST_CYCLES + WD_MARGIN);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        mem_impl_out_t exp_out;
        mem_data_t     be;

        RstN      = 1'b0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_bit_en = '0;
        wr_data   = '0;
        impl_in   = '0;
        rd_check  = 1'b0;
        pde_prev  = 1'b0;
        for (int w = 0; w < DEPTH; w++) begin
            ref_mem[w] = '0;
        end
        repeat (RESET_CYCLES) @(posedge Clk);
        #1 RstN = 1'b1;

        start_test("reset");
        @(negedge Clk);
        exp_out.prn = 1'b0;
        check_data("read data", '0, rd_data);
        check_impl("prn", exp_out, impl_out);
        finish_test();

        // Full words into every rank, the partial last rank included
        start_test("full_words");
        for (int a = 0; a < DEPTH; a++) begin
            drive_cycle(1'b0, '0, 1'b1, mem_addr_t'(a), '1, rand_word());
        end
        read_all();
        finish_test();

        start_test("random_masked");
        for (int i = 0; i < N_RAND; i++) begin
            case (i % 4)
                0: be = 40'h00000FF000;
                1: be = 40'h0FF0000000;
                default: be = rand_word();
            endcase
            drive_cycle($random(seed) & 1, rand_addr(), $random(seed) & 1, rand_addr(),
                        be, rand_word());
        end
        finish_test();

        // Retention held high so the contents survive this test
        start_test("prn_timing");
        @(posedge Clk);
        #1;
        impl_in.ret = 1'b1;
        impl_in.pde = 1'b1;
        // Falling edge number c comes after c rising edges have sampled pde
        for (int c = 0; c <= CHAIN_LEN; c++) begin
            @(negedge Clk);
            exp_out.prn = (c == CHAIN_LEN);
            check_impl($sformatf("prn rise cycle %0d", c), exp_out, impl_out);
        end
        @(posedge Clk);
        #1 impl_in.pde = 1'b0;
        for (int c = 0; c <= CHAIN_LEN; c++) begin
            @(negedge Clk);
            exp_out.prn = (c != CHAIN_LEN);
            check_impl($sformatf("prn fall cycle %0d", c), exp_out, impl_out);
        end
        @(posedge Clk);
        #1 impl_in.ret = 1'b0;
        finish_test();

        start_test("retention");
        power_cycle(1'b1);
        read_all();
        finish_test();

        start_test("power_clear");
        power_cycle(1'b0);
        read_all();
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
